// ==== hdl/alu_exec_pkg.sv ====
`default_nettype none

package alu_exec_pkg;

  ////////////////////
  // Widths

  localparam int XLEN    = 32; // Default data width
  localparam int PC_W    = 32;
  localparam int RFIDX_W = 5;  // Register file index

  ////////////////////
  // Decode encodings

  typedef enum logic {
    GRP_ALU = 1'b0,
    GRP_BJP = 1'b1
  } grp_e;

  // Regular ALU opcodes
  typedef enum logic [3:0] {
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_OR,
    OP_AND,
    OP_SLT,
    OP_SLTU,
    OP_LUI
  } alu_op_e;

  // Branch and jump opcodes
  typedef enum logic [2:0] {
    BJP_BEQ,
    BJP_BNE,
    BJP_BLT,
    BJP_BGE,
    BJP_BLTU,
    BJP_BGEU,
    BJP_JAL
  } bjp_op_e;

  // Function seen by the shared datapath
  typedef enum logic [3:0] {
    DP_ADD,
    DP_SUB,
    DP_XOR,
    DP_SLL,
    DP_SRL,
    DP_SRA,
    DP_OR,
    DP_AND,
    DP_SLT,
    DP_SLTU,
    DP_LUI,
    DP_CMP_EQ,  // Branch compares reuse the subtractor
    DP_CMP_LT,
    DP_CMP_LTU
  } dp_func_e;

endpackage

`default_nettype wire

// ==== hdl/alu_exec_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none

// Registered instruction from the issue stage
interface issue_if #(
  parameter int XLEN_P = alu_exec_pkg::XLEN
);
  import alu_exec_pkg::*;

  logic               valid;
  logic               ready;   // From the retire side
  dp_func_e           func;
  logic [XLEN_P-1:0]  op1;
  logic [XLEN_P-1:0]  op2;
  logic               is_bjp;
  logic               bjp_neg; // Invert compare for BNE and BGE
  logic               is_jal;
  logic               is_excp;
  logic [PC_W-1:0]    pc;
  logic [RFIDX_W-1:0] rdidx;
  logic               rdwen;
  logic               prdt;

  modport src (output valid, func, op1, op2, is_bjp, bjp_neg, is_jal, is_excp,
               output pc, rdidx, rdwen, prdt, input ready);
  modport dst (input valid, func, op1, op2, is_bjp, bjp_neg, is_jal, is_excp,
               input pc, rdidx, rdwen, prdt, output ready);
endinterface

// Resolved result toward the retire side
interface res_if #(
  parameter int XLEN_P = alu_exec_pkg::XLEN
);
  logic [XLEN_P-1:0] wdat;
  logic              bjp;
  logic              rslv;
  logic              prdt;

  modport src (output wdat, bjp, rslv, prdt);
  modport dst (input wdat, bjp, rslv, prdt);
endinterface

`default_nettype wire

// ==== hdl/alu_issue_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_issue_stage #(
  parameter int XLEN_P = alu_exec_pkg::XLEN
) (
  input  logic                            clk,
  input  logic                            i_rst_n,
  input  logic                            i_valid,
  output logic                            o_ready,
  input  alu_exec_pkg::grp_e              i_grp,
  input  logic [3:0]                      i_op,
  input  logic                            i_use_imm,
  input  logic [XLEN_P-1:0]               i_rs1,
  input  logic [XLEN_P-1:0]               i_rs2,
  input  logic [XLEN_P-1:0]               i_imm,
  input  logic [alu_exec_pkg::PC_W-1:0]   i_pc,
  input  logic [alu_exec_pkg::RFIDX_W-1:0] i_rdidx,
  input  logic                            i_rdwen,
  input  logic                            i_bjp_prdt,
  input  logic                            i_ilegl,
  issue_if.src                            iss
);
  import alu_exec_pkg::*;

  logic              ent_vld;
  logic              accept;
  dp_func_e          nxt_func;
  logic [XLEN_P-1:0] nxt_op2;
  logic              nxt_is_bjp;
  logic              nxt_bjp_neg;
  logic              nxt_is_jal;
  logic              nxt_rdwen;

  ////////////////////
  // Acceptance

  assign o_ready   = ~ent_vld | iss.ready; // Empty or leaving this cycle
  assign accept    = i_valid & o_ready;
  assign iss.valid = ent_vld;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      ent_vld <= 1'b0;
    end else if (o_ready) begin
      ent_vld <= i_valid;
    end
  end

  ////////////////////
  // Decode

  always_comb begin
    nxt_func    = DP_ADD;
    nxt_op2     = i_use_imm ? i_imm : i_rs2;
    nxt_is_bjp  = (i_grp == GRP_BJP);
    nxt_bjp_neg = 1'b0;
    nxt_is_jal  = 1'b0;
    nxt_rdwen   = i_rdwen;
    if (i_grp == GRP_ALU) begin
      case (alu_op_e'(i_op))
        OP_SUB:  nxt_func = DP_SUB;
        OP_XOR:  nxt_func = DP_XOR;
        OP_SLL:  nxt_func = DP_SLL;
        OP_SRL:  nxt_func = DP_SRL;
        OP_SRA:  nxt_func = DP_SRA;
        OP_OR:   nxt_func = DP_OR;
        OP_AND:  nxt_func = DP_AND;
        OP_SLT:  nxt_func = DP_SLT;
        OP_SLTU: nxt_func = DP_SLTU;
        OP_LUI:  nxt_func = DP_LUI;
        default: nxt_func = DP_ADD;
      endcase
    end else begin
      nxt_op2   = i_rs2; // Compare is always rs1 against rs2
      nxt_rdwen = 1'b0;
      case (bjp_op_e'(i_op[2:0]))
        BJP_BEQ:  nxt_func = DP_CMP_EQ;
        BJP_BNE: begin
          nxt_func    = DP_CMP_EQ;
          nxt_bjp_neg = 1'b1;
        end
        BJP_BLT:  nxt_func = DP_CMP_LT;
        BJP_BGE: begin
          nxt_func    = DP_CMP_LT;
          nxt_bjp_neg = 1'b1;
        end
        BJP_BLTU: nxt_func = DP_CMP_LTU;
        BJP_BGEU: begin
          nxt_func    = DP_CMP_LTU;
          nxt_bjp_neg = 1'b1;
        end
        default: begin
          nxt_is_jal = 1'b1; // Link value written back
          nxt_rdwen  = i_rdwen;
        end
      endcase
    end
    // Fetch exception overrides any branch decode
    if (i_ilegl) begin
      nxt_is_bjp  = 1'b0;
      nxt_bjp_neg = 1'b0;
      nxt_is_jal  = 1'b0;
    end
  end

  // Payload, loaded only on acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      iss.func    <= nxt_func;
      iss.op1     <= i_rs1;
      iss.op2     <= nxt_op2;
      iss.is_bjp  <= nxt_is_bjp;
      iss.bjp_neg <= nxt_bjp_neg;
      iss.is_jal  <= nxt_is_jal;
      iss.is_excp <= i_ilegl;
      iss.pc      <= i_pc;
      iss.rdidx   <= i_rdidx;
      iss.rdwen   <= nxt_rdwen;
      iss.prdt    <= i_bjp_prdt;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/alu_shared_dpath.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_shared_dpath #(
  parameter int XLEN_P = alu_exec_pkg::XLEN
) (
  issue_if.dst              iss,
  output logic [XLEN_P-1:0] o_res,
  output logic              o_cmp
);
  import alu_exec_pkg::*;

  localparam int SHAMT_W = $clog2(XLEN_P);

  logic                     do_sub;
  logic [XLEN_P:0]          add_res;  // Top bit is the carry out
  logic                     cmp_ltu;
  logic                     cmp_lt;
  logic                     cmp_eq;
  logic                     sh_left;
  logic                     sh_arith;
  logic [SHAMT_W-1:0]       shamt;
  logic [XLEN_P-1:0]        sh_in;
  logic signed [XLEN_P:0]   sh_ext;
  logic [XLEN_P-1:0]        sh_right;

  function automatic logic [XLEN_P-1:0] bit_rev(input logic [XLEN_P-1:0] v);
    for (int i = 0; i < XLEN_P; i++) begin
      bit_rev[i] = v[XLEN_P-1-i];
    end
  endfunction

  ////////////////////
  // Adder / subtractor

  assign do_sub = iss.func inside {DP_SUB, DP_SLT, DP_SLTU, DP_CMP_EQ, DP_CMP_LT, DP_CMP_LTU};

  assign add_res = {1'b0, iss.op1}
                 + {1'b0, iss.op2 ^ {XLEN_P{do_sub}}}
                 + {{XLEN_P{1'b0}}, do_sub};

  assign cmp_ltu = ~add_res[XLEN_P]; // Borrow
  // Sign correction when the operand signs differ
  assign cmp_lt  = cmp_ltu ^ (iss.op1[XLEN_P-1] ^ iss.op2[XLEN_P-1]);
  assign cmp_eq  = ~|add_res[XLEN_P-1:0];

  ////////////////////
  // Barrel shifter

  // Left shift done as a right shift of the reversed operand
  assign sh_left  = (iss.func == DP_SLL);
  assign sh_arith = (iss.func == DP_SRA);
  assign shamt    = iss.op2[SHAMT_W-1:0];
  assign sh_in    = sh_left ? bit_rev(iss.op1) : iss.op1;
  assign sh_ext   = $signed({sh_arith & iss.op1[XLEN_P-1], sh_in}) >>> shamt;
  assign sh_right = sh_ext[XLEN_P-1:0];

  ////////////////////
  // Result select

  always_comb begin
    case (iss.func)
      DP_ADD, DP_SUB: o_res = add_res[XLEN_P-1:0];
      DP_XOR:         o_res = iss.op1 ^ iss.op2;
      DP_SLL:         o_res = bit_rev(sh_right);
      DP_SRL, DP_SRA: o_res = sh_right;
      DP_OR:          o_res = iss.op1 | iss.op2;
      DP_AND:         o_res = iss.op1 & iss.op2;
      DP_SLT:         o_res = {{(XLEN_P-1){1'b0}}, cmp_lt};
      DP_SLTU:        o_res = {{(XLEN_P-1){1'b0}}, cmp_ltu};
      DP_LUI:         o_res = iss.op2; // Immediate already shifted
      default:        o_res = '0;
    endcase
  end

  always_comb begin
    case (iss.func)
      DP_CMP_EQ:  o_cmp = cmp_eq;
      DP_CMP_LT:  o_cmp = cmp_lt;
      DP_CMP_LTU: o_cmp = cmp_ltu;
      default:    o_cmp = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/alu_bjp_resolve.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_bjp_resolve #(
  parameter int XLEN_P = alu_exec_pkg::XLEN
) (
  issue_if.dst             iss,
  input  logic [XLEN_P-1:0] i_res,
  input  logic             i_cmp,
  res_if.src               res
);

  logic [XLEN_P-1:0] link_addr;
  logic              taken;

  ////////////////////
  // Branch outcome

  // BNE/BGE reuse the EQ/LT compare, inverted here
  assign taken = iss.is_jal | (i_cmp ^ iss.bjp_neg);

  assign res.bjp  = iss.is_bjp;
  assign res.rslv = iss.is_bjp & taken;
  assign res.prdt = iss.is_bjp & iss.prdt; // Prediction only matters for branches

  ////////////////////
  // Write-back data

  assign link_addr = XLEN_P'(iss.pc) + XLEN_P'(4); // Return address for JAL

  always_comb begin
    if (iss.is_jal) begin
      res.wdat = link_addr;
    end else begin
      res.wdat = i_res;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/alu_retire_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_retire_arb #(
  parameter int XLEN_P = alu_exec_pkg::XLEN
) (
  issue_if.dst                              iss,
  res_if.dst                                res,
  input  logic                              i_cmt_ready,
  input  logic                              i_wbck_ready,
  output logic                              o_cmt_valid,
  output logic [alu_exec_pkg::PC_W-1:0]     o_cmt_pc,
  output logic                              o_cmt_bjp,
  output logic                              o_cmt_bjp_prdt,
  output logic                              o_cmt_bjp_rslv,
  output logic                              o_cmt_ilegl,
  output logic                              o_wbck_valid,
  output logic [XLEN_P-1:0]                 o_wbck_wdat,
  output logic [alu_exec_pkg::RFIDX_W-1:0]  o_wbck_rdidx
);

  logic err;
  logic need_wbck;

  ////////////////////
  // Joined handshake

  // Illegal instruction retires as an error and never writes rd
  assign err       = iss.is_excp;
  assign need_wbck = iss.rdwen & ~err;

  // Each side waits for the other so both complete on the same edge
  assign o_cmt_valid  = iss.valid & (need_wbck ? i_wbck_ready : 1'b1);
  assign o_wbck_valid = need_wbck & iss.valid & i_cmt_ready;

  assign iss.ready = i_cmt_ready & (need_wbck ? i_wbck_ready : 1'b1);

  ////////////////////
  // Commit fields

  assign o_cmt_pc       = iss.pc;
  assign o_cmt_bjp      = res.bjp;
  assign o_cmt_bjp_prdt = res.prdt;
  assign o_cmt_bjp_rslv = res.rslv;
  assign o_cmt_ilegl    = err;

  ////////////////////
  // Write-back fields

  always_comb begin
    if (err) begin
      o_wbck_wdat = '0;
    end else begin
      o_wbck_wdat = res.wdat;
    end
  end

  assign o_wbck_rdidx = iss.rdidx;

endmodule

`default_nettype wire

// ==== hdl/alu_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_exec_top #(
  parameter int XLEN_P = alu_exec_pkg::XLEN
) (
  input  logic                              clk,
  input  logic                              i_rst_n,
  // Issue side
  input  logic                              i_valid,
  output logic                              o_ready,
  input  alu_exec_pkg::grp_e                i_grp,
  input  logic [3:0]                        i_op,
  input  logic                              i_use_imm,
  input  logic [XLEN_P-1:0]                 i_rs1,
  input  logic [XLEN_P-1:0]                 i_rs2,
  input  logic [XLEN_P-1:0]                 i_imm,
  input  logic [alu_exec_pkg::PC_W-1:0]     i_pc,
  input  logic [alu_exec_pkg::RFIDX_W-1:0]  i_rdidx,
  input  logic                              i_rdwen,
  input  logic                              i_bjp_prdt,
  input  logic                              i_ilegl,
  // Commit channel
  output logic                              o_cmt_valid,
  input  logic                              i_cmt_ready,
  output logic [alu_exec_pkg::PC_W-1:0]     o_cmt_pc,
  output logic                              o_cmt_bjp,
  output logic                              o_cmt_bjp_prdt,
  output logic                              o_cmt_bjp_rslv,
  output logic                              o_cmt_ilegl,
  // Write-back channel
  output logic                              o_wbck_valid,
  input  logic                              i_wbck_ready,
  output logic [XLEN_P-1:0]                 o_wbck_wdat,
  output logic [alu_exec_pkg::RFIDX_W-1:0]  o_wbck_rdidx
);

  logic [XLEN_P-1:0] dp_res;
  logic              dp_cmp;

  issue_if #(.XLEN_P(XLEN_P)) iss_bus ();
  res_if   #(.XLEN_P(XLEN_P)) res_bus ();

  ////////////////////
  // Input register

  alu_issue_stage #(.XLEN_P(XLEN_P)) u_issue_stage (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_valid    (i_valid),
    .o_ready    (o_ready),
    .i_grp      (i_grp),
    .i_op       (i_op),
    .i_use_imm  (i_use_imm),
    .i_rs1      (i_rs1),
    .i_rs2      (i_rs2),
    .i_imm      (i_imm),
    .i_pc       (i_pc),
    .i_rdidx    (i_rdidx),
    .i_rdwen    (i_rdwen),
    .i_bjp_prdt (i_bjp_prdt),
    .i_ilegl    (i_ilegl),
    .iss        (iss_bus.src)
  );

  ////////////////////
  // Processing, all combinational

  alu_shared_dpath #(.XLEN_P(XLEN_P)) u_shared_dpath (
    .iss   (iss_bus.dst),
    .o_res (dp_res),
    .o_cmp (dp_cmp)
  );

  alu_bjp_resolve #(.XLEN_P(XLEN_P)) u_bjp_resolve (
    .iss   (iss_bus.dst),
    .i_res (dp_res),
    .i_cmp (dp_cmp),
    .res   (res_bus.src)
  );

  ////////////////////
  // Commit and write-back

  alu_retire_arb #(.XLEN_P(XLEN_P)) u_retire_arb (
    .iss            (iss_bus.dst),
    .res            (res_bus.dst),
    .i_cmt_ready    (i_cmt_ready),
    .i_wbck_ready   (i_wbck_ready),
    .o_cmt_valid    (o_cmt_valid),
    .o_cmt_pc       (o_cmt_pc),
    .o_cmt_bjp      (o_cmt_bjp),
    .o_cmt_bjp_prdt (o_cmt_bjp_prdt),
    .o_cmt_bjp_rslv (o_cmt_bjp_rslv),
    .o_cmt_ilegl    (o_cmt_ilegl),
    .o_wbck_valid   (o_wbck_valid),
    .o_wbck_wdat    (o_wbck_wdat),
    .o_wbck_rdidx   (o_wbck_rdidx)
  );

endmodule

`default_nettype wire

// ==== verification/alu_exec_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_exec_asserts (
  input logic                          clk,
  input logic                          i_rst_n,
  input logic                          i_cmt_ready,
  input logic                          i_cmt_valid,
  input logic                          i_wbck_valid,
  input logic [alu_exec_pkg::PC_W-1:0] i_cmt_pc,
  input logic                          i_cmt_bjp,
  input logic                          i_cmt_bjp_prdt,
  input logic                          i_cmt_bjp_rslv,
  input logic                          i_cmt_ilegl
);

  // Write-back is only offered when commit can take the entry too
  wbck_needs_cmt_ready: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_wbck_valid |-> i_cmt_ready)
    else $error("write-back valid while commit ready is low");

  // Stalled commit holds its fields
  cmt_stable_on_stall: assert property (@(posedge clk) disable iff (!i_rst_n)
    (i_cmt_valid && !i_cmt_ready) |=>
      $stable({i_cmt_pc, i_cmt_bjp, i_cmt_bjp_prdt, i_cmt_bjp_rslv, i_cmt_ilegl}))
    else $error("commit fields changed during back-pressure");

  cmt_idle_after_reset: assert property (@(posedge clk) !i_rst_n |=> !i_cmt_valid)
    else $error("commit valid in the cycle after reset");

endmodule

bind alu_exec_top alu_exec_asserts u_asserts (
  .clk            (clk),
  .i_rst_n        (i_rst_n),
  .i_cmt_ready    (i_cmt_ready),
  .i_cmt_valid    (o_cmt_valid),
  .i_wbck_valid   (o_wbck_valid),
  .i_cmt_pc       (o_cmt_pc),
  .i_cmt_bjp      (o_cmt_bjp),
  .i_cmt_bjp_prdt (o_cmt_bjp_prdt),
  .i_cmt_bjp_rslv (o_cmt_bjp_rslv),
  .i_cmt_ilegl    (o_cmt_ilegl)
);

`default_nettype wire

// ==== verification/alu_exec_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_exec_tb;
  import alu_exec_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int SEED       = 32'h6b17;
  localparam int N_ALU_REP  = 3;
  localparam int N_BP       = 30;
  localparam int N_TPUT     = 20;
  localparam int MAX_CYCLES = 200 * 10; // About 200 instructions at ten cycles each under stalls
  localparam int SH_W       = $clog2(XLEN);
  localparam int OUT_W      = PC_W + XLEN + RFIDX_W + 4;

  // Expected retirement of one instruction
  typedef struct packed {
    logic [PC_W-1:0]    pc;
    logic               bjp;
    logic               prdt;
    logic               rslv;
    logic               ilegl;
    logic               wb;
    logic [XLEN-1:0]    wdat;
    logic [RFIDX_W-1:0] rdidx;
  } exp_t;

  logic clk;
  logic i_rst_n;
  logic i_valid;
  logic o_ready;
  grp_e i_grp;
  logic [3:0] i_op;
  logic i_use_imm;
  logic [XLEN-1:0] i_rs1;
  logic [XLEN-1:0] i_rs2;
  logic [XLEN-1:0] i_imm;
  logic [PC_W-1:0] i_pc;
  logic [RFIDX_W-1:0] i_rdidx;
  logic i_rdwen;
  logic i_bjp_prdt;
  logic i_ilegl;
  logic o_cmt_valid;
  logic i_cmt_ready;
  logic [PC_W-1:0] o_cmt_pc;
  logic o_cmt_bjp;
  logic o_cmt_bjp_prdt;
  logic o_cmt_bjp_rslv;
  logic o_cmt_ilegl;
  logic o_wbck_valid;
  logic i_wbck_ready;
  logic [XLEN-1:0] o_wbck_wdat;
  logic [RFIDX_W-1:0] o_wbck_rdidx;

  exp_t            exp_q[$];
  string           cur_test = "reset";
  int              n_checks = 0;
  int              n_errors = 0;
  int              n_sent = 0;
  int              n_retired = 0;
  int              cyc = 0;
  int              acc_cyc = 0;
  int              last_ret_cyc = 0;
  int              stall_left = 0;
  int unsigned     seed_init;
  logic            bp_on;
  logic            held;
  logic [PC_W-1:0] pc_next;
  logic [OUT_W-1:0] out_now;
  logic [OUT_W-1:0] out_snap;

  alu_exec_top #(.XLEN_P(XLEN)) dut (
    .clk (clk), .i_rst_n (i_rst_n), .i_valid (i_valid), .o_ready (o_ready),
    .i_grp (i_grp), .i_op (i_op), .i_use_imm (i_use_imm), .i_rs1 (i_rs1),
    .i_rs2 (i_rs2), .i_imm (i_imm), .i_pc (i_pc), .i_rdidx (i_rdidx),
    .i_rdwen (i_rdwen), .i_bjp_prdt (i_bjp_prdt), .i_ilegl (i_ilegl),
    .o_cmt_valid (o_cmt_valid), .i_cmt_ready (i_cmt_ready), .o_cmt_pc (o_cmt_pc),
    .o_cmt_bjp (o_cmt_bjp), .o_cmt_bjp_prdt (o_cmt_bjp_prdt),
    .o_cmt_bjp_rslv (o_cmt_bjp_rslv), .o_cmt_ilegl (o_cmt_ilegl),
    .o_wbck_valid (o_wbck_valid), .i_wbck_ready (i_wbck_ready),
    .o_wbck_wdat (o_wbck_wdat), .o_wbck_rdidx (o_wbck_rdidx)
  );

  assign out_now = {o_cmt_pc, o_cmt_bjp, o_cmt_bjp_prdt, o_cmt_bjp_rslv, o_cmt_ilegl,
                    o_wbck_wdat, o_wbck_rdidx};

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= MAX_CYCLES) begin
      $display("Timeout after %0d cycles, %0d instructions in flight", cyc, exp_q.size());
      $display("TEST RESULT: FAIL");
      $finish;
    end
  end

  ////////////////////
  // Reference model

  function automatic logic [XLEN-1:0] alu_model(input alu_op_e op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    case (op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_XOR:  return a ^ b;
      OP_SLL:  return a << b[SH_W-1:0];
      OP_SRL:  return a >> b[SH_W-1:0];
      OP_SRA:  return $unsigned($signed(a) >>> b[SH_W-1:0]);
      OP_OR:   return a | b;
      OP_AND:  return a & b;
      OP_SLT:  return ($signed(a) < $signed(b)) ? XLEN'(1) : XLEN'(0);
      OP_SLTU: return (a < b) ? XLEN'(1) : XLEN'(0);
      default: return b; // LUI takes the shifted immediate
    endcase
  endfunction

  function automatic logic branch_taken(input bjp_op_e op, input logic [XLEN-1:0] a,
                                        input logic [XLEN-1:0] b);
    case (op)
      BJP_BEQ:  return a == b;
      BJP_BNE:  return a != b;
      BJP_BLT:  return $signed(a) < $signed(b);
      BJP_BGE:  return $signed(a) >= $signed(b);
      BJP_BLTU: return a < b;
      BJP_BGEU: return a >= b;
      default:  return 1'b1;
    endcase
  endfunction

  ////////////////////
  // Checking helpers

  task automatic report_error(input string msg);
    n_errors++;
    $display("Error in %s at cycle %0d: %s", cur_test, cyc, msg);
  endtask

  task automatic check_val(input string what, input logic [63:0] exp_v,
                           input logic [63:0] act_v);
    n_checks++;
    if (act_v !== exp_v) begin
      n_errors++;
      $display("Mismatch in %s: %s expected %0h actual %0h", cur_test, what, exp_v, act_v);
    end
  endtask

  task automatic retire_check;
    exp_t e;
    e = exp_q.pop_front();
    check_val("commit pc", e.pc, o_cmt_pc);
    check_val("commit bjp", e.bjp, o_cmt_bjp);
    check_val("commit bjp_prdt", e.prdt, o_cmt_bjp_prdt);
    check_val("commit bjp_rslv", e.rslv, o_cmt_bjp_rslv);
    check_val("commit ilegl", e.ilegl, o_cmt_ilegl);
    check_val("wbck valid", e.wb, o_wbck_valid);
    if (e.wb) begin
      check_val("wbck wdat", e.wdat, o_wbck_wdat);
      check_val("wbck rdidx", e.rdidx, o_wbck_rdidx);
    end else if (e.ilegl) begin
      check_val("wbck wdat", '0, o_wbck_wdat); // Exception entries carry no data
    end
    last_ret_cyc = cyc;
  endtask

  // Handshake and retire monitor on the falling edge
  always @(negedge clk) begin
    if (i_rst_n) begin
      if (o_wbck_valid && !i_cmt_ready) report_error("write-back valid with commit ready low");
      if (held && out_now !== out_snap) report_error("outputs changed while entry was stalled");
      if (o_cmt_valid && i_cmt_ready) n_retired++; // Every retire handshake at the ports
      if (exp_q.size() == 0) begin
        if (o_cmt_valid || o_wbck_valid) report_error("retire valid with nothing in flight");
        if (!o_ready) report_error("o_ready low with the stage empty");
      end else begin
        if (!i_cmt_ready && o_ready) report_error("o_ready high while commit is stalled");
        if (o_wbck_valid && !exp_q[0].wb) report_error("write-back for an entry without one");
        if (o_cmt_valid && i_cmt_ready) retire_check();
      end
      held     = !o_ready; // Entry stays through the next edge
      out_snap = out_now;
    end
  end

  // Retire side readiness held in random stretches under back-pressure
  always @(posedge clk) begin
    #1;
    if (!bp_on) begin
      i_cmt_ready  = 1'b1;
      i_wbck_ready = 1'b1;
    end else if (stall_left == 0) begin
      stall_left   = $urandom_range(5, 1);
      i_cmt_ready  = ($urandom_range(1, 0) == 1);
      i_wbck_ready = ($urandom_range(1, 0) == 1);
    end else begin
      stall_left--;
    end
  end

  ////////////////////
  // Stimulus

  task automatic send(input grp_e grp, input logic [3:0] op, input logic use_imm,
                      input logic [XLEN-1:0] rs1, input logic [XLEN-1:0] rs2,
                      input logic [XLEN-1:0] imm, input logic rdwen, input logic prdt,
                      input logic ilegl);
    exp_t e;
    logic acc;
    e       = '0;
    e.pc    = pc_next;
    e.rdidx = RFIDX_W'($urandom);
    e.ilegl = ilegl;
    if (!ilegl && grp == GRP_ALU) begin
      e.wb   = rdwen;
      e.wdat = alu_model(alu_op_e'(op), rs1, use_imm ? imm : rs2);
    end else if (!ilegl) begin
      e.bjp  = 1'b1;
      e.prdt = prdt;
      e.rslv = branch_taken(bjp_op_e'(op[2:0]), rs1, rs2);
      e.wb   = rdwen && (op[2:0] == BJP_JAL); // Only JAL links
      e.wdat = XLEN'(e.pc) + XLEN'(4);
    end
    i_valid    = 1'b1;
    i_grp      = grp;
    i_op       = op;
    i_use_imm  = use_imm;
    i_rs1      = rs1;
    i_rs2      = rs2;
    i_imm      = imm;
    i_pc       = e.pc;
    i_rdidx    = e.rdidx;
    i_rdwen    = rdwen;
    i_bjp_prdt = prdt;
    i_ilegl    = ilegl;
    acc = 1'b0;
    while (!acc) begin
      @(negedge clk);
      acc = o_ready;
      if (acc) acc_cyc = cyc;
      @(posedge clk);
      #1;
    end
    exp_q.push_back(e);
    pc_next = pc_next + PC_W'(4);
    n_sent++;
  endtask

  task automatic drain;
    i_valid = 1'b0;
    while (exp_q.size() > 0) @(negedge clk);
    @(posedge clk);
    #1;
  endtask

  ////////////////////
  // Directed tests

  task automatic test_alu_ops;
    cur_test = "alu_ops";
    for (int rep = 0; rep < N_ALU_REP; rep++) begin
      for (int k = 0; k <= int'(OP_LUI); k++) begin
        send(GRP_ALU, 4'(k), 1'(k + rep), $urandom, $urandom, $urandom, 1'b1, 1'b0, 1'b0);
      end
    end
    drain();
  endtask

  task automatic test_no_wbck;
    cur_test = "no_wbck";
    for (int k = 0; k < 4; k++) begin
      send(GRP_ALU, 4'(k), 1'(k), $urandom, $urandom, $urandom, 1'b0, 1'b0, 1'b0);
    end
    drain();
  endtask

  task automatic test_branches;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] tmp;
    logic            sgn;
    logic            a_below;
    cur_test = "branches";
    for (int op = 0; op <= int'(BJP_JAL); op++) begin
      // Kind 0 equal, 1 less-than, 2 greater-than
      for (int kind = 0; kind < 3; kind++) begin
        a       = $urandom;
        b       = (kind == 0) ? a : $urandom;
        sgn     = (op == int'(BJP_BLT)) || (op == int'(BJP_BGE));
        a_below = sgn ? ($signed(a) < $signed(b)) : (a < b);
        if (kind != 0 && a_below != (kind == 1)) begin
          tmp = a;
          a   = b;
          b   = tmp;
        end
        send(GRP_BJP, 4'(op), 1'($urandom), a, b, $urandom, 1'b1, 1'($urandom), 1'b0);
      end
    end
    drain();
  endtask

  task automatic test_exception;
    cur_test = "exception";
    send(GRP_ALU, 4'(OP_ADD), 1'b0, $urandom, $urandom, $urandom, 1'b1, 1'b0, 1'b1);
    send(GRP_ALU, 4'(OP_SLT), 1'b1, $urandom, $urandom, $urandom, 1'b1, 1'b1, 1'b1);
    send(GRP_BJP, 4'(BJP_BEQ), 1'b0, 32'h5, 32'h5, $urandom, 1'b1, 1'b1, 1'b1);
    send(GRP_BJP, 4'(BJP_JAL), 1'b0, $urandom, $urandom, $urandom, 1'b1, 1'b1, 1'b1);
    drain();
  endtask

  task automatic test_backpressure;
    int start;
    cur_test = "backpressure";
    start    = n_retired;
    bp_on    = 1'b1;
    for (int i = 0; i < N_BP; i++) begin
      if ($urandom_range(1, 0) == 1) begin
        send(GRP_ALU, 4'($urandom_range(int'(OP_LUI), 0)), 1'($urandom), $urandom, $urandom,
             $urandom, 1'($urandom), 1'b0, 1'b0);
      end else begin
        send(GRP_BJP, 4'($urandom_range(int'(BJP_JAL), 0)), 1'($urandom), $urandom, $urandom,
             $urandom, 1'($urandom), 1'($urandom), 1'b0);
      end
    end
    drain();
    bp_on = 1'b0;
    @(posedge clk);
    #1;
    if (n_retired - start != N_BP) report_error("not every stalled instruction retired once");
  endtask

  task automatic test_throughput;
    int first_acc;
    cur_test  = "throughput";
    first_acc = 0;
    for (int i = 0; i < N_TPUT; i++) begin
      send(GRP_ALU, 4'($urandom_range(int'(OP_LUI), 0)), 1'($urandom), $urandom, $urandom,
           $urandom, 1'b1, 1'b0, 1'b0);
      if (i == 0) first_acc = acc_cyc;
    end
    drain();
    if (last_ret_cyc - first_acc > N_TPUT + 1) begin
      report_error($sformatf("%0d instructions took %0d cycles to retire", N_TPUT,
                             last_ret_cyc - first_acc));
    end
  endtask

  initial begin
    seed_init  = $urandom(SEED);
    i_rst_n    = 1'b0;
    i_valid    = 1'b0;
    i_grp      = GRP_ALU;
    i_op       = '0;
    i_use_imm  = 1'b0;
    i_rs1      = '0;
    i_rs2      = '0;
    i_imm      = '0;
    i_pc       = '0;
    i_rdidx    = '0;
    i_rdwen    = 1'b0;
    i_bjp_prdt = 1'b0;
    i_ilegl    = 1'b0;
    i_cmt_ready  = 1'b1;
    i_wbck_ready = 1'b1;
    bp_on      = 1'b0;
    held       = 1'b0;
    pc_next    = PC_W'(32'h1000);
    repeat (2) @(posedge clk);
    #1;
    i_rst_n = 1'b1;

    @(negedge clk);
    check_val("o_ready", 1, o_ready);
    check_val("o_cmt_valid", 0, o_cmt_valid);
    check_val("o_wbck_valid", 0, o_wbck_valid);
    @(posedge clk);
    #1;

    test_alu_ops();
    test_no_wbck();
    test_branches();
    test_exception();
    test_backpressure();
    test_throughput();

    $display("Checks: %0d, errors: %0d, sent: %0d, retired: %0d",
             n_checks, n_errors, n_sent, n_retired);
    if (n_errors == 0 && n_sent == n_retired) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== alu_exec_top.f ====
hdl/alu_exec_pkg.sv
hdl/alu_exec_ifs.sv
hdl/alu_issue_stage.sv
hdl/alu_shared_dpath.sv
hdl/alu_bjp_resolve.sv
hdl/alu_retire_arb.sv
hdl/alu_exec_top.sv
verification/alu_exec_asserts.sv
verification/alu_exec_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the execution stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=alu_exec_sim
LOG=sim.log

verilator --binary --assert -Wno-fatal \
  --top-module alu_exec_tb \
  -f alu_exec_top.f \
  --Mdir "$BUILD_DIR" -o "$SIM_BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
  exit 0
fi
echo "Pass line not found in $LOG"
exit 1
